// File: arch_alu.f
design/arch_defs_pkg.sv
design/arith_unit.sv
design/logic_unit.sv
design/alu_result_reg.sv
design/alu.sv
bench/alu_checker.sv
bench/tb_alu.sv

// File: bench/alu_checker.sv
module alu_checker #(
    parameter int DATA_WIDTH = arch_defs_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [DATA_WIDTH-1:0]  in_one_i,
    input  logic [DATA_WIDTH-1:0]  in_two_i,
    input  logic                   in_carry_i,
    input  arch_defs_pkg::alu_op_t alu_op_i,
    input  logic [DATA_WIDTH-1:0]  latched_result_i,
    input  logic                   carry_flag_i,
    input  logic                   zero_flag_i,
    input  logic                   negative_flag_i,
    input  logic                   tbl_valid_i,     // Row carries its own expected values
    input  logic [DATA_WIDTH-1:0]  tbl_result_i,
    input  logic [2:0]             tbl_flags_i,     // {carry, zero, negative}
    output int                     err_count_o,
    output int                     check_count_o,
    output logic                   ready_o          // Model holds a known state
);
    timeunit 1ns;
    timeprecision 100ps;
    import arch_defs_pkg::*;

    int                    errors = 0;
    int                    checks = 0;
    logic                  ready = 1'b0;
    logic [DATA_WIDTH-1:0] exp_res;
    logic                  exp_c;
    logic                  exp_z;
    logic                  exp_n;
    alu_op_t               last_op;
    logic                  tbl_pending;
    logic [DATA_WIDTH-1:0] tbl_res;
    logic [2:0]            tbl_fl;

    assign err_count_o   = errors;
    assign check_count_o = checks;
    assign ready_o       = ready;

    // Carry out is the bit above the top of the sum
    function automatic logic [DATA_WIDTH:0] add_bits(longint unsigned x, longint unsigned y);
        longint unsigned s;
        s = x + y;
        return s[DATA_WIDTH:0];
    endfunction

    // Carry set means no borrow, i.e. x >= y
    function automatic logic [DATA_WIDTH:0] sub_bits(longint x, longint y);
        longint d;
        d = x - y;
        return {d >= 0, d[DATA_WIDTH-1:0]};
    endfunction

    task automatic step_model(input alu_op_t op, input logic [DATA_WIDTH-1:0] a,
                              input logic [DATA_WIDTH-1:0] b, input logic ci);
        logic [DATA_WIDTH-1:0] res;
        logic                  carry;
        res   = '0;
        carry = 1'b0;
        case (op)
            ALU_ADD: {carry, res} = add_bits(a, b);
            ALU_ADC: {carry, res} = add_bits(a, b + ci);
            ALU_SUB, ALU_CMP: {carry, res} = sub_bits(a, b);
            ALU_SBC: {carry, res} = sub_bits(a, b + !ci);  // Clear carry in is a borrow
            ALU_INR: {carry, res} = add_bits(a, 1);
            ALU_DCR: {carry, res} = sub_bits(a, 1);
            ALU_AND: res = a & b;
            ALU_OR:  res = a | b;
            ALU_XOR: res = a ^ b;
            ALU_NOT: res = ~a;
            ALU_SHL: {carry, res} = {a, 1'b0};
            ALU_SHR: {res, carry} = {1'b0, a};
            ALU_RLC: {carry, res} = {a, ci};
            ALU_RRC: {res, carry} = {ci, a};
            default: ;                              // NOP changes nothing
        endcase
        if (op != ALU_NOP) begin
            if (op != ALU_CMP) begin
                exp_res = res;
            end
            exp_c = carry;
            exp_z = (res == '0);
            exp_n = res[DATA_WIDTH-1];
        end
    endtask

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %0h, expected %0h after op %0d",
                     $time, what, got, exp, last_op);
        end
    endtask

    // Same inputs the DUT registers on this edge
    always @(posedge clk) begin
        if (reset) begin
            exp_res     = '0;
            exp_c       = 1'b0;
            exp_z       = 1'b1;
            exp_n       = 1'b0;
            last_op     = ALU_NOP;
            tbl_pending = 1'b0;
            ready      <= 1'b1;
        end else if (ready) begin
            step_model(alu_op_i, in_one_i, in_two_i, in_carry_i);
            last_op     = alu_op_i;
            tbl_pending = tbl_valid_i;
            tbl_res     = tbl_result_i;
            tbl_fl      = tbl_flags_i;
        end
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (ready) begin
            checks++;
            compare("latched_result", latched_result_i, exp_res);
            compare("carry_flag", carry_flag_i, exp_c);
            compare("zero_flag", zero_flag_i, exp_z);
            compare("negative_flag", negative_flag_i, exp_n);
            if (tbl_pending) begin
                compare("table result", latched_result_i, tbl_res);
                compare("table flags", {carry_flag_i, zero_flag_i, negative_flag_i}, tbl_fl);
            end
        end
    end

endmodule

// File: bench/tb_alu.sv
module tb_alu;
    timeunit 1ns;
    timeprecision 100ps;
    import arch_defs_pkg::*;

    localparam int DATA_WIDTH    = 8;
    localparam int RESET_CYCLES  = 3;
    localparam int RANDOM_CYCLES = 200;
    localparam int WAIT_LIMIT    = 50;     // Cycles before a wait gives up

    typedef struct packed {
        alu_op_t               op;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic                  ci;
        logic [DATA_WIDTH-1:0] res;
        logic [2:0]            flags;   // {carry, zero, negative}
    } row_t;

    logic                  clk = 1'b0;
    logic                  reset;
    logic [DATA_WIDTH-1:0] in_one;
    logic [DATA_WIDTH-1:0] in_two;
    logic                  in_carry;
    alu_op_t               alu_op;
    logic [DATA_WIDTH-1:0] latched_result;
    logic                  zero_flag;
    logic                  carry_flag;
    logic                  negative_flag;
    logic                  tbl_valid;
    logic [DATA_WIDTH-1:0] tbl_result;
    logic [2:0]            tbl_flags;
    int                    err_count;
    int                    check_count;
    logic                  ready;
    logic                  timed_out;
    integer                seed;
    row_t                  rows[$];

    always #4 clk = ~clk;      // 8 ns period

    alu #(
        .DATA_WIDTH (DATA_WIDTH)
    ) uut (
        .clk              (clk),
        .reset            (reset),
        .in_one_i         (in_one),
        .in_two_i         (in_two),
        .in_carry_i       (in_carry),
        .alu_op_i         (alu_op),
        .latched_result_o (latched_result),
        .zero_flag_o      (zero_flag),
        .carry_flag_o     (carry_flag),
        .negative_flag_o  (negative_flag)
    );

    alu_checker #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_checker (
        .clk              (clk),
        .reset            (reset),
        .in_one_i         (in_one),
        .in_two_i         (in_two),
        .in_carry_i       (in_carry),
        .alu_op_i         (alu_op),
        .latched_result_i (latched_result),
        .carry_flag_i     (carry_flag),
        .zero_flag_i      (zero_flag),
        .negative_flag_i  (negative_flag),
        .tbl_valid_i      (tbl_valid),
        .tbl_result_i     (tbl_result),
        .tbl_flags_i      (tbl_flags),
        .err_count_o      (err_count),
        .check_count_o    (check_count),
        .ready_o          (ready)
    );

    task automatic add_row(input alu_op_t op, input logic [DATA_WIDTH-1:0] a,
                           input logic [DATA_WIDTH-1:0] b, input logic ci,
                           input logic [DATA_WIDTH-1:0] res, input logic c,
                           input logic z, input logic n);
        rows.push_back({op, a, b, ci, res, c, z, n});
    endtask

    // op, operand one, operand two, carry in, then expected result, C, Z, N
    task automatic build_rows();
        add_row(ALU_ADD, 8'hFF, 8'h01, 1'b0, 8'h00, 1, 1, 0);  // Carry out of bit 7
        add_row(ALU_ADD, 8'd100, 8'd27, 1'b1, 8'd127, 0, 0, 0); // Carry in ignored
        add_row(ALU_ADC, 8'd200, 8'd55, 1'b1, 8'h00, 1, 1, 0);
        add_row(ALU_ADC, 8'd120, 8'd8, 1'b1, 8'h81, 0, 0, 1);
        add_row(ALU_SUB, 8'd50, 8'd20, 1'b0, 8'd30, 1, 0, 0);
        add_row(ALU_SUB, 8'd20, 8'd50, 1'b0, 8'hE2, 0, 0, 1);   // Borrow
        add_row(ALU_SBC, 8'd50, 8'd20, 1'b0, 8'd29, 1, 0, 0);
        add_row(ALU_SBC, 8'd20, 8'd20, 1'b0, 8'hFF, 0, 0, 1);
        add_row(ALU_SBC, 8'd20, 8'd20, 1'b1, 8'h00, 1, 1, 0);
        add_row(ALU_INR, 8'hFF, 8'h00, 1'b0, 8'h00, 1, 1, 0);   // Wrap at 255
        add_row(ALU_INR, 8'h7F, 8'h00, 1'b0, 8'h80, 0, 0, 1);
        add_row(ALU_DCR, 8'h00, 8'h00, 1'b0, 8'hFF, 0, 0, 1);   // Wrap at 0
        add_row(ALU_DCR, 8'h01, 8'h00, 1'b0, 8'h00, 1, 1, 0);
        add_row(ALU_AND, 8'hF0, 8'h3C, 1'b1, 8'h30, 0, 0, 0);
        add_row(ALU_OR,  8'h80, 8'h01, 1'b1, 8'h81, 0, 0, 1);
        add_row(ALU_XOR, 8'hAA, 8'hAA, 1'b0, 8'h00, 0, 1, 0);
        add_row(ALU_NOT, 8'h0F, 8'hFF, 1'b0, 8'hF0, 0, 0, 1);
        add_row(ALU_SHL, 8'h81, 8'h00, 1'b0, 8'h02, 1, 0, 0);
        add_row(ALU_SHR, 8'h81, 8'h00, 1'b1, 8'h40, 1, 0, 0);
        add_row(ALU_RLC, 8'h80, 8'h00, 1'b1, 8'h01, 1, 0, 0);
        add_row(ALU_RLC, 8'h40, 8'h00, 1'b0, 8'h80, 0, 0, 1);
        add_row(ALU_RRC, 8'h01, 8'h00, 1'b0, 8'h00, 1, 1, 0);
        add_row(ALU_RRC, 8'h02, 8'h00, 1'b1, 8'h81, 0, 0, 1);
        add_row(ALU_CMP, 8'd10, 8'd10, 1'b0, 8'h81, 1, 1, 0);   // Result holds
        add_row(ALU_CMP, 8'd5, 8'd9, 1'b0, 8'h81, 0, 0, 1);
        add_row(ALU_NOP, 8'h01, 8'h02, 1'b0, 8'h81, 0, 0, 1);
        add_row(ALU_NOP, 8'hFF, 8'hFF, 1'b1, 8'h81, 0, 0, 1);
        add_row(ALU_NOP, 8'h00, 8'h00, 1'b0, 8'h81, 0, 0, 1);
        add_row(ALU_ADD, 8'h0F, 8'h01, 1'b0, 8'h10, 0, 0, 0);
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!ready && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!ready) begin
            $display("Timeout: the checker never saw the reset");
            timed_out = 1'b1;
        end
    endtask

    task automatic apply_rows();
        foreach (rows[i]) begin
            @(posedge clk);
            alu_op     <= rows[i].op;
            in_one     <= rows[i].a;
            in_two     <= rows[i].b;
            in_carry   <= rows[i].ci;
            tbl_valid  <= 1'b1;
            tbl_result <= rows[i].res;
            tbl_flags  <= rows[i].flags;
        end
    endtask

    task automatic apply_random();
        logic [31:0] draw;
        repeat (RANDOM_CYCLES) begin
            @(posedge clk);
            draw = $random(seed);
            alu_op    <= draw[3:0];
            in_carry  <= draw[4];
            draw = $random(seed);
            in_one    <= draw[DATA_WIDTH-1:0];
            draw = $random(seed);
            in_two    <= draw[DATA_WIDTH-1:0];
            tbl_valid <= 1'b0;
        end
    endtask

    // Last operation is compared one edge after it is sampled
    task automatic wait_drain();
        int cycles;
        int target;
        cycles = 0;
        target = check_count + 2;
        while (check_count < target && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (check_count < target) begin
            $display("Timeout: the checker did not compare the last operations");
            timed_out = 1'b1;
        end
    endtask

    initial begin
        seed       = 32'h3731872a;
        timed_out  = 1'b0;
        reset      = 1'b1;
        in_one     = '0;
        in_two     = '0;
        in_carry   = 1'b0;
        alu_op     = ALU_NOP;
        tbl_valid  = 1'b0;
        tbl_result = '0;
        tbl_flags  = '0;
        build_rows();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        wait_ready();
        if (!timed_out) begin
            apply_rows();
            apply_random();
            wait_drain();
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, err_count, timed_out);
        if (timed_out || err_count != 0) begin
            $display("SOME TESTS FAILED");
        end else begin
            $display("ALL TESTS PASSED");
        end
        $finish;
    end

endmodule

// File: design/alu.sv
module alu #(
    parameter int DATA_WIDTH = arch_defs_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [DATA_WIDTH-1:0]  in_one_i,
    input  logic [DATA_WIDTH-1:0]  in_two_i,
    input  logic                   in_carry_i,
    input  arch_defs_pkg::alu_op_t alu_op_i,
    output logic [DATA_WIDTH-1:0]  latched_result_o,
    output logic                   zero_flag_o,
    output logic                   carry_flag_o,
    output logic                   negative_flag_o
);
    import arch_defs_pkg::*;

    logic [DATA_WIDTH-1:0] arith_res;
    logic                  arith_carry;
    logic [DATA_WIDTH-1:0] logic_res;
    logic                  logic_carry;
    flags_t                flags;

    // Both units see every operation and decode only their own codes
    arith_unit #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_arith_unit (
        .in_one_i      (in_one_i),
        .in_two_i      (in_two_i),
        .in_carry_i    (in_carry_i),
        .alu_op_i      (alu_op_i),
        .arith_res_o   (arith_res),
        .arith_carry_o (arith_carry)
    );

    logic_unit #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_logic_unit (
        .in_one_i      (in_one_i),
        .in_two_i      (in_two_i),
        .in_carry_i    (in_carry_i),
        .alu_op_i      (alu_op_i),
        .logic_res_o   (logic_res),
        .logic_carry_o (logic_carry)
    );

    // One cycle of latency lives here
    alu_result_reg #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_alu_result_reg (
        .clk              (clk),
        .reset            (reset),
        .alu_op_i         (alu_op_i),
        .arith_res_i      (arith_res),
        .arith_carry_i    (arith_carry),
        .logic_res_i      (logic_res),
        .logic_carry_i    (logic_carry),
        .latched_result_o (latched_result_o),
        .flags_o          (flags)
    );

    assign carry_flag_o    = flags[FLAG_C];
    assign zero_flag_o     = flags[FLAG_Z];
    assign negative_flag_o = flags[FLAG_N];

endmodule

// File: design/alu_result_reg.sv
module alu_result_reg #(
    parameter int DATA_WIDTH = arch_defs_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                   clk,
    input  logic                   reset,
    input  arch_defs_pkg::alu_op_t alu_op_i,
    input  logic [DATA_WIDTH-1:0]  arith_res_i,
    input  logic                   arith_carry_i,
    input  logic [DATA_WIDTH-1:0]  logic_res_i,
    input  logic                   logic_carry_i,
    output logic [DATA_WIDTH-1:0]  latched_result_o,
    output arch_defs_pkg::flags_t  flags_o
);
    import arch_defs_pkg::*;

    logic [DATA_WIDTH-1:0] sel_res;
    logic                  sel_carry;
    logic                  logic_class;     // Bit 3 of the code
    flags_t                next_flags;
    logic                  result_we;       // Result register load
    logic                  flags_we;        // Flag register load

    assign logic_class = alu_op_i[OP_CLASS_BIT];

    // Pick the pair from the unit that owns this code
    always_comb begin
        if (logic_class) begin
            sel_res   = logic_res_i;
            sel_carry = logic_carry_i;
        end else begin
            sel_res   = arith_res_i;
            sel_carry = arith_carry_i;
        end
    end

    // Flags follow the selected result
    always_comb begin
        next_flags         = '0;
        next_flags[FLAG_C] = sel_carry;
        next_flags[FLAG_Z] = (sel_res == '0);
        next_flags[FLAG_N] = sel_res[DATA_WIDTH-1];
    end

    // CMP only touches the flags, NOP touches nothing
    assign result_we = (alu_op_i != ALU_CMP) && (alu_op_i != ALU_NOP);
    assign flags_we  = (alu_op_i != ALU_NOP);

    always_ff @(posedge clk) begin
        if (reset) begin
            latched_result_o <= '0;
        end else if (result_we) begin
            latched_result_o <= sel_res;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags_o <= FLAGS_RESET;     // Cleared result reads as zero
        end else if (flags_we) begin
            flags_o <= next_flags;
        end
    end

endmodule

// File: design/arch_defs_pkg.sv
package arch_defs_pkg;

    // Operand width when the top level does not override it
    localparam int DEFAULT_DATA_WIDTH = 8;

    // Operation code
    localparam int OP_WIDTH = 4;
    localparam int OP_CLASS_BIT = 3;    // 0 arithmetic, 1 logic/shift

    typedef logic [OP_WIDTH-1:0] alu_op_t;

    // Arithmetic class, served by the adder
    localparam alu_op_t ALU_ADD = 4'd0;     // A + B
    localparam alu_op_t ALU_ADC = 4'd1;     // A + B + carry in
    localparam alu_op_t ALU_SUB = 4'd2;     // A - B
    localparam alu_op_t ALU_SBC = 4'd3;     // A - B, carry in means no borrow
    localparam alu_op_t ALU_INR = 4'd4;     // A + 1
    localparam alu_op_t ALU_DCR = 4'd5;     // A - 1
    localparam alu_op_t ALU_CMP = 4'd6;     // A - B, flags only
    localparam alu_op_t ALU_NOP = 4'd7;     // Hold everything

    // Logic class, bitwise operations on A and B
    localparam alu_op_t ALU_AND = 4'd8;
    localparam alu_op_t ALU_OR  = 4'd9;
    localparam alu_op_t ALU_XOR = 4'd10;
    localparam alu_op_t ALU_NOT = 4'd11;    // Inverts A only

    // Logic class, one-bit moves of A
    localparam alu_op_t ALU_SHL = 4'd12;    // Zero enters at bit 0
    localparam alu_op_t ALU_SHR = 4'd13;    // Zero enters at the top
    localparam alu_op_t ALU_RLC = 4'd14;    // Rotate left through carry
    localparam alu_op_t ALU_RRC = 4'd15;    // Rotate right through carry

    // Status flags
    localparam int FLAG_COUNT = 3;

    typedef logic [FLAG_COUNT-1:0] flags_t;

    // Bit positions inside flags_t
    localparam int FLAG_C = 0;      // Carry, or no borrow on subtraction
    localparam int FLAG_Z = 1;      // Result is all zeros
    localparam int FLAG_N = 2;      // Top bit of the result

    // Value after reset: a cleared result reads as zero
    localparam flags_t FLAGS_RESET = 3'b010;

endpackage

// File: design/arith_unit.sv
module arith_unit #(
    parameter int DATA_WIDTH = arch_defs_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic [DATA_WIDTH-1:0]  in_one_i,
    input  logic [DATA_WIDTH-1:0]  in_two_i,
    input  logic                   in_carry_i,
    input  arch_defs_pkg::alu_op_t alu_op_i,
    output logic [DATA_WIDTH-1:0]  arith_res_o,
    output logic                   arith_carry_o
);
    import arch_defs_pkg::*;

    localparam logic [DATA_WIDTH-1:0] ONE = {{(DATA_WIDTH-1){1'b0}}, 1'b1};

    logic [DATA_WIDTH-1:0] addend;      // Second adder input
    logic                  carry_in;    // Adder carry input
    logic                  arith_en;    // Code belongs to this unit
    logic [DATA_WIDTH:0]   sum;         // One bit wider for the carry out

    // Subtraction runs as A + ~B + 1, so the carry out reads as "no borrow"
    always_comb begin
        case (alu_op_i)
            ALU_ADD,
            ALU_ADC: begin
                addend = in_two_i;
            end
            ALU_SUB,
            ALU_SBC,
            ALU_CMP: begin
                addend = ~in_two_i;
            end
            ALU_INR: begin
                addend = ONE;
            end
            ALU_DCR: begin
                addend = ~ONE;      // With carry in set this adds all ones
            end
            default: begin
                addend = '0;
            end
        endcase
    end

    always_comb begin
        case (alu_op_i)
            ALU_ADC,
            ALU_SBC: begin
                carry_in = in_carry_i;  // SBC takes carry in as no borrow
            end
            ALU_SUB,
            ALU_CMP,
            ALU_DCR: begin
                carry_in = 1'b1;        // Completes the two's complement
            end
            default: begin
                carry_in = 1'b0;
            end
        endcase
    end

    // NOP and every logic code leave this unit quiet
    always_comb begin
        case (alu_op_i)
            ALU_ADD,
            ALU_ADC,
            ALU_SUB,
            ALU_SBC,
            ALU_INR,
            ALU_DCR,
            ALU_CMP: begin
                arith_en = 1'b1;
            end
            default: begin
                arith_en = 1'b0;
            end
        endcase
    end

    // Single shared adder
    assign sum = {1'b0, in_one_i} + {1'b0, addend} + {{DATA_WIDTH{1'b0}}, carry_in};

    assign arith_res_o   = arith_en ? sum[DATA_WIDTH-1:0] : '0;
    assign arith_carry_o = arith_en & sum[DATA_WIDTH];  // Bit above the top of the sum

endmodule

// File: design/logic_unit.sv
module logic_unit #(
    parameter int DATA_WIDTH = arch_defs_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic [DATA_WIDTH-1:0]  in_one_i,
    input  logic [DATA_WIDTH-1:0]  in_two_i,
    input  logic                   in_carry_i,
    input  arch_defs_pkg::alu_op_t alu_op_i,
    output logic [DATA_WIDTH-1:0]  logic_res_o,
    output logic                   logic_carry_o
);
    import arch_defs_pkg::*;

    logic [DATA_WIDTH-1:0] bitwise_res;     // AND, OR, XOR, NOT
    logic [DATA_WIDTH-1:0] move_res;        // Shifts and rotates
    logic                  move_carry;      // Bit pushed out by a move
    logic                  move_en;

    always_comb begin
        case (alu_op_i)
            ALU_AND: bitwise_res = in_one_i & in_two_i;
            ALU_OR:  bitwise_res = in_one_i | in_two_i;
            ALU_XOR: bitwise_res = in_one_i ^ in_two_i;
            ALU_NOT: bitwise_res = ~in_one_i;
            default: bitwise_res = '0;
        endcase
    end

    // Only operand one moves
    always_comb begin
        move_en = 1'b1;
        case (alu_op_i)
            ALU_SHL: begin
                move_res   = {in_one_i[DATA_WIDTH-2:0], 1'b0};
                move_carry = in_one_i[DATA_WIDTH-1];
            end
            ALU_SHR: begin
                move_res   = {1'b0, in_one_i[DATA_WIDTH-1:1]};
                move_carry = in_one_i[0];
            end
            ALU_RLC: begin
                // Old carry enters at bit 0, top bit leaves into carry
                move_res   = {in_one_i[DATA_WIDTH-2:0], in_carry_i};
                move_carry = in_one_i[DATA_WIDTH-1];
            end
            ALU_RRC: begin
                // Old carry enters at the top, bit 0 leaves into carry
                move_res   = {in_carry_i, in_one_i[DATA_WIDTH-1:1]};
                move_carry = in_one_i[0];
            end
            default: begin
                move_res   = '0;
                move_carry = 1'b0;
                move_en    = 1'b0;
            end
        endcase
    end

    // Arithmetic codes give zeros here
    always_comb begin
        if (move_en) begin
            logic_res_o   = move_res;
            logic_carry_o = move_carry;
        end else begin
            logic_res_o   = bitwise_res;
            logic_carry_o = 1'b0;           // Bitwise ops never carry
        end
    end

endmodule
